// File: commit/rob.sv
// ----------------------------------------------------------
// circular reorder buffer, cdb writeback, operand lookup
// and in-order commit of one entry per cycle
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module rob (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     dispatch_valid,
    input  ooo_pkg::tag_t            dispatch_tag,
    input  logic [`OOO_REG_BITS-1:0] dispatch_rd,
    output logic                     rob_full,
    output ooo_pkg::tag_t            alloc_tag,
    input  logic                     cdb_valid,
    input  ooo_pkg::tag_t            cdb_tag,
    input  ooo_pkg::data_t           cdb_data,
    input  ooo_pkg::tag_t            lookup1_tag,
    input  ooo_pkg::tag_t            lookup2_tag,
    output logic                     lookup1_ready,
    output ooo_pkg::data_t           lookup1_data,
    output logic                     lookup2_ready,
    output ooo_pkg::data_t           lookup2_data,
    output logic                     commit_valid,
    output logic [`OOO_REG_BITS-1:0] commit_rd,
    output ooo_pkg::data_t           commit_data,
    output ooo_pkg::tag_t            commit_tag
);

    localparam int CNT_BITS = `OOO_TAG_BITS + 1;

    ooo_pkg::tag_t             head;
    ooo_pkg::tag_t             tail;
    logic [CNT_BITS-1:0]       count;
    logic [`OOO_ROB_DEPTH-1:0] ent_done;
    logic [`OOO_REG_BITS-1:0]  ent_rd [`OOO_ROB_DEPTH];
    ooo_pkg::data_t            ent_value [`OOO_ROB_DEPTH];
    logic                      head_commit;

    assign alloc_tag   = tail;
    assign rob_full    = (count == CNT_BITS'(`OOO_ROB_DEPTH));
    assign head_commit = (count != '0) && ent_done[head];

    // done stays set after commit until the entry is reallocated,
    // so a lookup in the commit_valid cycle still finds the value
    assign lookup1_ready = ent_done[lookup1_tag];
    assign lookup1_data  = ent_value[lookup1_tag];
    assign lookup2_ready = ent_done[lookup2_tag];
    assign lookup2_data  = ent_value[lookup2_tag];

    // ----------------------------------------------------------
    // pointers, count and done bits
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            ent_done     <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= head_commit;
            if (head_commit)
                head <= head + 1'b1;
            if (dispatch_valid) begin
                tail                   <= tail + 1'b1;
                ent_done[dispatch_tag] <= 1'b0;
            end
            if (cdb_valid)
                ent_done[cdb_tag] <= 1'b1;
            count <= count + CNT_BITS'(dispatch_valid) - CNT_BITS'(head_commit);
        end
    end

    // ----------------------------------------------------------
    // entry payload and commit ports
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (dispatch_valid)
            ent_rd[dispatch_tag] <= dispatch_rd;
        if (cdb_valid)
            ent_value[cdb_tag] <= cdb_data;
        commit_rd   <= ent_rd[head];
        commit_data <= ent_value[head];
        commit_tag  <= head;
    end

endmodule

`default_nettype wire

// File: common/ooo_defs.svh
// ----------------------------------------------------------
// ooo core sizing and instruction word field positions
// ----------------------------------------------------------
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// architectural register file
`define OOO_NUM_REGS  8
`define OOO_REG_BITS  3

// reorder buffer and reservation station sizes
`define OOO_ROB_DEPTH 4
`define OOO_TAG_BITS  2
`define OOO_RS_DEPTH  2

// field ranges inside the 32-bit write data
`define OOO_F_OP  2:0
`define OOO_F_RD  5:3
`define OOO_F_RS1 8:6
`define OOO_F_RS2 11:9
`define OOO_F_IMM 19:12

`endif

// File: common/ooo_pkg.sv
// ----------------------------------------------------------
// shared types of the ooo core
// ----------------------------------------------------------
`default_nettype none

`include "ooo_defs.svh"

package ooo_pkg;

    // alu operations as encoded in instruction bits 2:0
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_or   = 3'd3,
        op_xor  = 3'd4,
        op_addi = 3'd5,
        op_lui  = 3'd6
    } opcode_e;

    // names one reorder buffer entry
    typedef logic [`OOO_TAG_BITS-1:0] tag_t;

    typedef logic [31:0] data_t;

endpackage

`default_nettype wire

// File: exec/rs_alu.sv
// ----------------------------------------------------------
// reservation station with cdb capture, oldest-ready pick
// and a single-cycle alu that drives the cdb
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module rs_alu (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             dispatch_valid,
    input  ooo_pkg::opcode_e dispatch_op,
    input  ooo_pkg::tag_t    dispatch_tag,
    input  ooo_pkg::data_t   dispatch_val1,
    input  logic             dispatch_rdy1,
    input  ooo_pkg::tag_t    dispatch_src1,
    input  ooo_pkg::data_t   dispatch_val2,
    input  logic             dispatch_rdy2,
    input  ooo_pkg::tag_t    dispatch_src2,
    output logic             rs_full,
    output logic             cdb_valid,
    output ooo_pkg::tag_t    cdb_tag,
    output ooo_pkg::data_t   cdb_data
);

    localparam int IDX_BITS = $clog2(`OOO_RS_DEPTH);

    logic [`OOO_RS_DEPTH-1:0] slot_valid;
    logic [3:0]               slot_age [`OOO_RS_DEPTH];
    ooo_pkg::opcode_e         slot_op [`OOO_RS_DEPTH];
    ooo_pkg::tag_t            slot_tag [`OOO_RS_DEPTH];
    ooo_pkg::data_t           slot_val1 [`OOO_RS_DEPTH];
    ooo_pkg::data_t           slot_val2 [`OOO_RS_DEPTH];
    logic [`OOO_RS_DEPTH-1:0] slot_rdy1;
    logic [`OOO_RS_DEPTH-1:0] slot_rdy2;
    ooo_pkg::tag_t            slot_src1 [`OOO_RS_DEPTH];
    ooo_pkg::tag_t            slot_src2 [`OOO_RS_DEPTH];

    logic                     sel_valid;
    logic [IDX_BITS-1:0]      sel_idx;
    logic [3:0]               sel_age;
    logic [IDX_BITS-1:0]      free_idx;

    function automatic ooo_pkg::data_t alu(
        input ooo_pkg::opcode_e op,
        input ooo_pkg::data_t   a,
        input ooo_pkg::data_t   b
    );
        case (op)
            ooo_pkg::op_sub: return a - b;
            ooo_pkg::op_and: return a & b;
            ooo_pkg::op_or:  return a | b;
            ooo_pkg::op_xor: return a ^ b;
            ooo_pkg::op_lui: return b << 8;
            // add and addi share the adder
            default:         return a + b;
        endcase
    endfunction

    assign rs_full = &slot_valid;

    // oldest slot with both operands ready, and the lowest free slot
    always_comb begin
        sel_valid = 1'b0;
        sel_idx   = '0;
        sel_age   = '0;
        free_idx  = '0;
        for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i])
                free_idx = IDX_BITS'(i);
        end
        for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
            if (slot_valid[i] && slot_rdy1[i] && slot_rdy2[i] &&
                (!sel_valid || slot_age[i] > sel_age)) begin
                sel_valid = 1'b1;
                sel_idx   = IDX_BITS'(i);
                sel_age   = slot_age[i];
            end
        end
    end

    // ----------------------------------------------------------
    // slot occupancy and age
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_valid <= '0;
            cdb_valid  <= 1'b0;
            for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
                slot_age[i] <= '0;
            end
        end else begin
            cdb_valid <= sel_valid;
            for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
                if (sel_valid && sel_idx == IDX_BITS'(i))
                    slot_valid[i] <= 1'b0;
                else if (slot_valid[i] && slot_age[i] != 4'hf)
                    slot_age[i] <= slot_age[i] + 4'd1;
            end
            if (dispatch_valid) begin
                slot_valid[free_idx] <= 1'b1;
                slot_age[free_idx]   <= '0;
            end
        end
    end

    // ----------------------------------------------------------
    // operand capture and alu result
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
            if (cdb_valid && !slot_rdy1[i] && slot_src1[i] == cdb_tag) begin
                slot_rdy1[i] <= 1'b1;
                slot_val1[i] <= cdb_data;
            end
            if (cdb_valid && !slot_rdy2[i] && slot_src2[i] == cdb_tag) begin
                slot_rdy2[i] <= 1'b1;
                slot_val2[i] <= cdb_data;
            end
        end
        if (dispatch_valid) begin
            // the issue stage already forwards a cdb hit in the dispatch cycle
            slot_op[free_idx]   <= dispatch_op;
            slot_tag[free_idx]  <= dispatch_tag;
            slot_src1[free_idx] <= dispatch_src1;
            slot_src2[free_idx] <= dispatch_src2;
            slot_rdy1[free_idx] <= dispatch_rdy1;
            slot_val1[free_idx] <= dispatch_val1;
            slot_rdy2[free_idx] <= dispatch_rdy2;
            slot_val2[free_idx] <= dispatch_val2;
        end
        cdb_tag  <= slot_tag[sel_idx];
        cdb_data <= alu(slot_op[sel_idx], slot_val1[sel_idx], slot_val2[sel_idx]);
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+common
common/ooo_pkg.sv
issue/issue_stage.sv
exec/rs_alu.sv
commit/rob.sv
verilog/ooo_core.sv
verif/tb_clock.sv
verif/tb_ooo_core.sv

// File: issue/issue_stage.sv
// ----------------------------------------------------------
// issue stage, wishbone write slave, decode, register file
// and register status table with operand lookup
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module issue_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [31:0]              wb_dat_w,
    output logic                     wb_ack,
    input  logic                     rs_full,
    input  logic                     rob_full,
    input  ooo_pkg::tag_t            alloc_tag,
    output logic                     dispatch_valid,
    output ooo_pkg::opcode_e         dispatch_op,
    output ooo_pkg::tag_t            dispatch_tag,
    output logic [`OOO_REG_BITS-1:0] dispatch_rd,
    output ooo_pkg::data_t           dispatch_val1,
    output logic                     dispatch_rdy1,
    output ooo_pkg::tag_t            dispatch_src1,
    output ooo_pkg::data_t           dispatch_val2,
    output logic                     dispatch_rdy2,
    output ooo_pkg::tag_t            dispatch_src2,
    output ooo_pkg::tag_t            lookup1_tag,
    output ooo_pkg::tag_t            lookup2_tag,
    input  logic                     lookup1_ready,
    input  ooo_pkg::data_t           lookup1_data,
    input  logic                     lookup2_ready,
    input  ooo_pkg::data_t           lookup2_data,
    input  logic                     cdb_valid,
    input  ooo_pkg::tag_t            cdb_tag,
    input  ooo_pkg::data_t           cdb_data,
    input  logic                     commit_valid,
    input  logic [`OOO_REG_BITS-1:0] commit_rd,
    input  ooo_pkg::data_t           commit_data,
    input  ooo_pkg::tag_t            commit_tag
);

    logic [`OOO_REG_BITS-1:0] rs1;
    logic [`OOO_REG_BITS-1:0] rs2;
    logic [7:0]               imm8;
    ooo_pkg::data_t           imm_se;
    logic                     use_imm;
    ooo_pkg::data_t           regs [`OOO_NUM_REGS];
    logic [`OOO_NUM_REGS-1:0] stat_busy;
    ooo_pkg::tag_t            stat_tag [`OOO_NUM_REGS];
    logic                     rdy1_src;
    logic                     rdy2_src;
    ooo_pkg::data_t           val1_src;
    ooo_pkg::data_t           val2_src;

    // operand source priority: regfile, then cdb, then rob, else wait on tag
    function automatic logic [32:0] resolve(
        input logic           busy,
        input ooo_pkg::tag_t  tag,
        input ooo_pkg::data_t reg_val,
        input logic           rob_ready,
        input ooo_pkg::data_t rob_data
    );
        if (!busy)
            return {1'b1, reg_val};
        if (cdb_valid && cdb_tag == tag)
            return {1'b1, cdb_data};
        if (rob_ready)
            return {1'b1, rob_data};
        return {1'b0, 32'h0};
    endfunction

    // decode, the master holds the data until ack
    assign dispatch_op  = ooo_pkg::opcode_e'(wb_dat_w[`OOO_F_OP]);
    assign dispatch_rd  = wb_dat_w[`OOO_F_RD];
    assign rs1          = wb_dat_w[`OOO_F_RS1];
    assign rs2          = wb_dat_w[`OOO_F_RS2];
    assign imm8         = wb_dat_w[`OOO_F_IMM];
    assign imm_se       = {{24{imm8[7]}}, imm8};
    assign use_imm      = (dispatch_op == ooo_pkg::op_addi) || (dispatch_op == ooo_pkg::op_lui);

    // dispatch lines up with the ack cycle
    assign dispatch_valid = wb_ack;
    assign dispatch_tag   = alloc_tag;

    assign lookup1_tag   = stat_tag[rs1];
    assign lookup2_tag   = stat_tag[rs2];
    assign dispatch_src1 = stat_tag[rs1];
    assign dispatch_src2 = stat_tag[rs2];

    always_comb begin
        {rdy1_src, val1_src} = resolve(stat_busy[rs1], stat_tag[rs1], regs[rs1],
                                       lookup1_ready, lookup1_data);
        {rdy2_src, val2_src} = resolve(stat_busy[rs2], stat_tag[rs2], regs[rs2],
                                       lookup2_ready, lookup2_data);
        // lui ignores rs1
        dispatch_rdy1 = rdy1_src || (dispatch_op == ooo_pkg::op_lui);
        dispatch_val1 = val1_src;
        dispatch_rdy2 = use_imm ? 1'b1 : rdy2_src;
        dispatch_val2 = use_imm ? imm_se : val2_src;
    end

    // ----------------------------------------------------------
    // ack, register file and status table
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack    <= 1'b0;
            stat_busy <= '0;
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // one-cycle ack, only while there is room downstream
            wb_ack <= wb_cyc && wb_stb && wb_we && !wb_ack && !rs_full && !rob_full;
            if (commit_valid) begin
                regs[commit_rd] <= commit_data;
                if (stat_busy[commit_rd] && stat_tag[commit_rd] == commit_tag)
                    stat_busy[commit_rd] <= 1'b0;
            end
            // a new writer wins over a clearing commit
            if (dispatch_valid)
                stat_busy[dispatch_rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid)
            stat_tag[dispatch_rd] <= alloc_tag;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the ooo core testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f files.f --top-module tb_ooo_core -o sim_ooo \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_ooo > sim.log 2>&1 || { cat sim.log; echo "simulation did not run"; exit 1; }
cat sim.log

# the log decides the result
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: verif/tb_clock.sv
// ----------------------------------------------------------
// testbench clock source, 10 ns period
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 10.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: verif/tb_ooo_core.sv
// ----------------------------------------------------------
// testbench for the ooo core, drives wishbone writes and
// checks every commit against an in-order reference model
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module tb_ooo_core;

    localparam int RANDOM_WRITES   = 200;
    // the directed tests issue fewer than 50 writes
    localparam int DIRECTED_WRITES = 50;
    localparam int CYCLE_LIMIT     = 16 * (DIRECTED_WRITES + RANDOM_WRITES);
    localparam int DRAIN_LIMIT     = 20 * `OOO_ROB_DEPTH;

    logic                     clk;
    logic                     arst_n;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [31:0]              wb_dat_w;
    logic                     wb_ack;
    logic                     commit_valid;
    logic [`OOO_REG_BITS-1:0] commit_rd;
    logic [31:0]              commit_data;

    // reference model state
    logic [31:0]                 model_regs [`OOO_NUM_REGS];
    logic [`OOO_REG_BITS+31:0]   exp_q [$];
    int                          in_flight;
    logic                        head_valid;
    logic [`OOO_REG_BITS-1:0]    head_rd;
    logic [31:0]                 head_data;

    logic        write_started;
    int          seed;
    int          cycle_count = 0;
    int          tests_run;
    int          tests_failed;
    int          idle_errs;
    int          commit_errs;
    int          flight_errs;
    int          drain_errs;

    tb_clock clock_inst (
        .clk (clk)
    );

    ooo_core ooo_core_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_dat_w     (wb_dat_w),
        .wb_ack       (wb_ack),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    function automatic logic [31:0] encode(
        input ooo_pkg::opcode_e         op,
        input logic [`OOO_REG_BITS-1:0] rd,
        input logic [`OOO_REG_BITS-1:0] rs1,
        input logic [`OOO_REG_BITS-1:0] rs2,
        input logic [7:0]               imm
    );
        logic [31:0] w;
        w = '0;
        w[`OOO_F_OP]  = op;
        w[`OOO_F_RD]  = rd;
        w[`OOO_F_RS1] = rs1;
        w[`OOO_F_RS2] = rs2;
        w[`OOO_F_IMM] = imm;
        return w;
    endfunction

    // result as the instruction set defines it
    function automatic logic [31:0] expected_result(
        input logic [31:0] instr,
        input logic [31:0] a,
        input logic [31:0] b
    );
        logic [31:0] imm;
        imm = {{24{instr[19]}}, instr[`OOO_F_IMM]};
        case (ooo_pkg::opcode_e'(instr[`OOO_F_OP]))
            ooo_pkg::op_add:  return a + b;
            ooo_pkg::op_sub:  return a - b;
            ooo_pkg::op_and:  return a & b;
            ooo_pkg::op_or:   return a | b;
            ooo_pkg::op_xor:  return a ^ b;
            ooo_pkg::op_addi: return a + imm;
            ooo_pkg::op_lui:  return imm << 8;
            default:          return 32'h0;
        endcase
    endfunction

    function automatic int total_errors();
        return idle_errs + commit_errs + flight_errs + drain_errs;
    endfunction

    // ----------------------------------------------------------
    // reference model in program order of acknowledged writes
    // ----------------------------------------------------------
    always @(posedge clk or negedge arst_n) begin
        logic [`OOO_REG_BITS-1:0] rd;
        logic [31:0]              value;
        if (!arst_n) begin
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                model_regs[i] = '0;
            end
            exp_q.delete();
            in_flight  <= 0;
            head_valid <= 1'b0;
            head_rd    <= '0;
            head_data  <= '0;
        end else begin
            if (commit_valid && exp_q.size() != 0)
                void'(exp_q.pop_front());
            if (wb_ack) begin
                rd    = wb_dat_w[`OOO_F_RD];
                value = expected_result(wb_dat_w, model_regs[wb_dat_w[`OOO_F_RS1]],
                                        model_regs[wb_dat_w[`OOO_F_RS2]]);
                model_regs[rd] = value;
                exp_q.push_back({rd, value});
            end
            in_flight  <= exp_q.size();
            head_valid <= (exp_q.size() != 0);
            if (exp_q.size() != 0) begin
                head_rd   <= exp_q[0][`OOO_REG_BITS+31:32];
                head_data <= exp_q[0][31:0];
            end
        end
    end

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------
    idle_check: assert property (@(posedge clk) disable iff (!arst_n)
        !write_started |-> (!wb_ack && !commit_valid))
        else begin
            idle_errs++;
            $display("ERROR %0t: ack or commit seen before the first write", $time);
        end

    commit_check: assert property (@(posedge clk) disable iff (!arst_n)
        commit_valid |-> (head_valid && commit_rd == head_rd && commit_data == head_data))
        else begin
            commit_errs++;
            $display("ERROR %0t: commit r%0d = %h, expected r%0d = %h (pending %0d)", $time,
                     $sampled(commit_rd), $sampled(commit_data), $sampled(head_rd),
                     $sampled(head_data), $sampled(in_flight));
        end

    flight_check: assert property (@(posedge clk) disable iff (!arst_n)
        in_flight <= `OOO_ROB_DEPTH)
        else begin
            flight_errs++;
            $display("ERROR %0t: %0d instructions in flight, more than the rob holds",
                     $time, $sampled(in_flight));
        end

    // run length guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // bus tasks and test reporting
    // ----------------------------------------------------------
    // called 1 ns after an edge and holds stb until ack
    task automatic wb_write(input logic [31:0] data);
        write_started = 1'b1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_dat_w = data;
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        int n;
        n = 0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        while (in_flight != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        drain_check: assert (in_flight == 0)
            else begin
                drain_errs++;
                $display("%0d acknowledged instructions never committed", in_flight);
            end
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int errs_before);
        int errs;
        errs = total_errors() - errs_before;
        tests_run++;
        if (errs != 0)
            tests_failed++;
        $display("test %0d %s: %s (%0d errors)", tests_run, name,
                 (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    // ----------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------
    initial begin
        int          errs;
        logic [31:0] rnd;
        logic [31:0] rnd_op;
        seed          = 32'ha18f;
        arst_n        = 1'b0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_dat_w      = '0;
        write_started = 1'b0;
        tests_run     = 0;
        tests_failed  = 0;
        idle_errs     = 0;
        commit_errs   = 0;
        flight_errs   = 0;
        drain_errs    = 0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (4) @(posedge clk);
        #1;

        // every register reads zero after reset
        errs = total_errors();
        for (int r = 0; r < `OOO_NUM_REGS; r++) begin
            wb_write(encode(ooo_pkg::op_addi, 3'(r), 3'(r), 3'd0, 8'(r + 1)));
        end
        wb_write(encode(ooo_pkg::op_lui, 3'd0, 3'd0, 3'd0, 8'h12));
        drain();
        report_test("reset and initial values", errs);

        // all seven opcodes with mixed operands
        errs = total_errors();
        for (int i = 0; i < 14; i++) begin
            wb_write(encode(ooo_pkg::opcode_e'(3'(i % 7)), 3'(i % 8), 3'((i + 3) % 8),
                            3'((i + 5) % 8), 8'(8'h9c + i * 17)));
        end
        drain();
        report_test("opcodes and commit order", errs);

        // rs1 reads the previous destination and rs2 the one before it
        errs = total_errors();
        for (int i = 0; i < 12; i++) begin
            wb_write(encode(ooo_pkg::opcode_e'(3'((i * 3) % 7)), 3'((i + 4) % 8),
                            3'((i + 3) % 8), 3'((i + 2) % 8), 8'(i * 29 + 5)));
        end
        drain();
        report_test("dependent chains", errs);

        // two writers of r5 in flight and the later one must win
        errs = total_errors();
        wb_write(encode(ooo_pkg::op_lui, 3'd6, 3'd0, 3'd0, 8'h40));
        wb_write(encode(ooo_pkg::op_addi, 3'd5, 3'd6, 3'd0, 8'h01));
        wb_write(encode(ooo_pkg::op_addi, 3'd5, 3'd0, 3'd0, 8'h07));
        // unrelated write so the first r5 writer commits before the reader issues
        wb_write(encode(ooo_pkg::op_xor, 3'd4, 3'd1, 3'd2, 8'h00));
        wb_write(encode(ooo_pkg::op_add, 3'd7, 3'd5, 3'd5, 8'h00));
        drain();
        report_test("register overwrite", errs);

        // back-to-back random stream
        errs = total_errors();
        for (int i = 0; i < RANDOM_WRITES; i++) begin
            rnd    = $random(seed);
            rnd_op = $unsigned($random(seed)) % 32'd7;
            wb_write(encode(ooo_pkg::opcode_e'(rnd_op[2:0]), rnd[2:0], rnd[5:3],
                            rnd[8:6], rnd[16:9]));
        end
        drain();
        report_test("random stream", errs);

        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/ooo_core.sv
// ----------------------------------------------------------
// ooo core top, issue feeds the station and the rob,
// the station drives the cdb and the rob commits in order
// ----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "ooo_defs.svh"

module ooo_core (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [31:0]              wb_dat_w,
    output logic                     wb_ack,
    output logic                     commit_valid,
    output logic [`OOO_REG_BITS-1:0] commit_rd,
    output ooo_pkg::data_t           commit_data
);

    logic                     rs_full;
    logic                     rob_full;
    ooo_pkg::tag_t            alloc_tag;

    // dispatch packet
    logic                     dispatch_valid;
    ooo_pkg::opcode_e         dispatch_op;
    ooo_pkg::tag_t            dispatch_tag;
    logic [`OOO_REG_BITS-1:0] dispatch_rd;
    ooo_pkg::data_t           dispatch_val1;
    logic                     dispatch_rdy1;
    ooo_pkg::tag_t            dispatch_src1;
    ooo_pkg::data_t           dispatch_val2;
    logic                     dispatch_rdy2;
    ooo_pkg::tag_t            dispatch_src2;

    // rob operand lookup
    ooo_pkg::tag_t            lookup1_tag;
    ooo_pkg::tag_t            lookup2_tag;
    logic                     lookup1_ready;
    logic                     lookup2_ready;
    ooo_pkg::data_t           lookup1_data;
    ooo_pkg::data_t           lookup2_data;

    // common data bus, single source
    logic                     cdb_valid;
    ooo_pkg::tag_t            cdb_tag;
    ooo_pkg::data_t           cdb_data;

    ooo_pkg::tag_t            commit_tag;

    // ----------------------------------------------------------
    // issue
    // ----------------------------------------------------------
    issue_stage issue_stage_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_dat_w       (wb_dat_w),
        .wb_ack         (wb_ack),
        .rs_full        (rs_full),
        .rob_full       (rob_full),
        .alloc_tag      (alloc_tag),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_tag   (dispatch_tag),
        .dispatch_rd    (dispatch_rd),
        .dispatch_val1  (dispatch_val1),
        .dispatch_rdy1  (dispatch_rdy1),
        .dispatch_src1  (dispatch_src1),
        .dispatch_val2  (dispatch_val2),
        .dispatch_rdy2  (dispatch_rdy2),
        .dispatch_src2  (dispatch_src2),
        .lookup1_tag    (lookup1_tag),
        .lookup2_tag    (lookup2_tag),
        .lookup1_ready  (lookup1_ready),
        .lookup1_data   (lookup1_data),
        .lookup2_ready  (lookup2_ready),
        .lookup2_data   (lookup2_data),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_tag     (commit_tag)
    );

    // ----------------------------------------------------------
    // execute and broadcast
    // ----------------------------------------------------------
    rs_alu rs_alu_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_tag   (dispatch_tag),
        .dispatch_val1  (dispatch_val1),
        .dispatch_rdy1  (dispatch_rdy1),
        .dispatch_src1  (dispatch_src1),
        .dispatch_val2  (dispatch_val2),
        .dispatch_rdy2  (dispatch_rdy2),
        .dispatch_src2  (dispatch_src2),
        .rs_full        (rs_full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data)
    );

    // ----------------------------------------------------------
    // commit
    // ----------------------------------------------------------
    rob rob_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_tag   (dispatch_tag),
        .dispatch_rd    (dispatch_rd),
        .rob_full       (rob_full),
        .alloc_tag      (alloc_tag),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_data       (cdb_data),
        .lookup1_tag    (lookup1_tag),
        .lookup2_tag    (lookup2_tag),
        .lookup1_ready  (lookup1_ready),
        .lookup1_data   (lookup1_data),
        .lookup2_ready  (lookup2_ready),
        .lookup2_data   (lookup2_data),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_tag     (commit_tag)
    );

endmodule

`default_nettype wire
